/* common/brisc_pkg.sv */
package brisc_pkg;

  // Architectural widths.
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // Data word, used for operands, results, PC+4 and load data.
  typedef logic [XLEN-1:0] xlen_t;

  // Register index.
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

endpackage

/* common/brisc_ctrl_pkg.sv */
package brisc_ctrl_pkg;

  // Writeback source select.
  typedef enum logic [1:0] {
    FROM_ALU     = 2'b00,
    FROM_CACHE   = 2'b01,
    FROM_PC_NEXT = 2'b10
  } result_src_e;

  // Exception causes reported at writeback.
  typedef enum logic [1:0] {
    NO_XCPT         = 2'b00,
    LOAD_MISALIGNED = 2'b01,
    ILLEGAL_MUL     = 2'b10
  } xcpt_e;

  typedef enum logic [2:0] {
    ADD = 3'b000,
    SUB = 3'b001,
    AND = 3'b010,
    OR  = 3'b011,
    XOR = 3'b100,
    SLT = 3'b101,
    SLL = 3'b110,
    SRL = 3'b111
  } alu_op_e;

  // Codes 3'b100 and up are undefined.
  typedef enum logic [2:0] {
    MUL    = 3'b000,
    MULH   = 3'b001,
    MULHSU = 3'b010,
    MULHU  = 3'b011
  } mul_op_e;

endpackage

/* common/exec_wb_if.sv */
`timescale 1ns/1ps

// ALU C stage towards writeback.
interface alu_wb_if;
  import brisc_pkg::*;
  import brisc_ctrl_pkg::*;

  logic        valid;
  xlen_t       res;
  reg_addr_t   rd;
  logic        reg_write;
  result_src_e result_src;
  xlen_t       pc_plus4;
  xcpt_e       xcpt;

  modport alu_src (
    output valid, res, rd, reg_write, result_src, pc_plus4, xcpt
  );

  modport wb_dst (
    input valid, res, rd, reg_write, result_src, pc_plus4, xcpt
  );

endinterface

// Last multiplier stage towards writeback.
interface mul_wb_if;
  import brisc_pkg::*;
  import brisc_ctrl_pkg::*;

  logic      valid;
  xlen_t     res;
  reg_addr_t rd;
  xcpt_e     xcpt;

  modport mul_src (output valid, res, rd, xcpt);

  modport wb_dst (input valid, res, rd, xcpt);

endinterface

/* hw/alu/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       flush,
  input  logic                       alu_valid,
  input  brisc_ctrl_pkg::alu_op_e     alu_op,
  input  brisc_pkg::xlen_t           op_a,
  input  brisc_pkg::xlen_t           op_b,
  input  brisc_pkg::xlen_t           pc_plus4,
  input  brisc_pkg::reg_addr_t       rd,
  input  logic                       reg_write,
  input  brisc_ctrl_pkg::result_src_e result_src,
  input  logic                       alu_stall,
  alu_wb_if.alu_src                  out
);
  import brisc_pkg::*;
  import brisc_ctrl_pkg::*;

  localparam int unsigned SHAMT_W = $clog2(XLEN);

  xlen_t alu_res;
  xcpt_e alu_xcpt;

  always_comb begin
    alu_res = '0;
    case (alu_op)
      ADD: alu_res = op_a + op_b;
      SUB: alu_res = op_a - op_b;
      AND: alu_res = op_a & op_b;
      OR:  alu_res = op_a | op_b;
      XOR: alu_res = op_a ^ op_b;
      SLT: alu_res = xlen_t'($signed(op_a) < $signed(op_b));
      SLL: alu_res = op_a << op_b[SHAMT_W-1:0];
      SRL: alu_res = op_a >> op_b[SHAMT_W-1:0];
      default: alu_res = '0;
    endcase
  end

  // Loads need a word-aligned address.
  assign alu_xcpt = (result_src == FROM_CACHE && alu_res[1:0] != 2'b00) ?
                    LOAD_MISALIGNED : NO_XCPT;

  //////////////////////////////////////////////////////////////////////
  // C stage register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      out.valid <= 1'b0;
    end else begin
      out.valid <= alu_valid && !alu_stall;
    end
  end

  always_ff @(posedge clk) begin
    out.res        <= alu_res;
    out.rd         <= rd;
    out.reg_write  <= reg_write;
    out.result_src <= result_src;
    out.pc_plus4   <= pc_plus4;
    out.xcpt       <= alu_xcpt;
  end

endmodule

/* hw/mul/mul_unit.sv */
`timescale 1ns/1ps

module mul_unit #(
  parameter int unsigned MUL_STAGES = 3
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush,
  input  logic                   mul_valid,
  input  brisc_ctrl_pkg::mul_op_e mul_op,
  input  brisc_pkg::xlen_t       op_a,
  input  brisc_pkg::xlen_t       op_b,
  input  brisc_pkg::reg_addr_t   rd,
  mul_wb_if.mul_src              out,
  output logic                   alu_stall
);
  import brisc_pkg::*;
  import brisc_ctrl_pkg::*;

  // Writeback adds one more register behind these.
  localparam int unsigned DEPTH = MUL_STAGES;

  logic                   sign_a, sign_b, high_half, legal;
  logic signed [XLEN:0]   a_ext, b_ext;
  logic signed [2*XLEN+1:0] product;
  xlen_t                  res_d;
  xcpt_e                  xcpt_d;

  logic [DEPTH-1:0] valid_q;
  xlen_t            res_q  [DEPTH];
  reg_addr_t        rd_q   [DEPTH];
  xcpt_e            xcpt_q [DEPTH];

  always_comb begin
    sign_a    = 1'b0;
    sign_b    = 1'b0;
    high_half = 1'b1;
    legal     = 1'b1;
    case (mul_op)
      MUL:    high_half = 1'b0;
      MULH: begin
        sign_a = 1'b1;
        sign_b = 1'b1;
      end
      MULHSU: sign_a = 1'b1;
      MULHU:  high_half = 1'b1;
      default: legal = 1'b0;
    endcase
  end

  assign a_ext   = {sign_a & op_a[XLEN-1], op_a};
  assign b_ext   = {sign_b & op_b[XLEN-1], op_b};
  assign product = a_ext * b_ext;

  always_comb begin
    res_d  = high_half ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];
    xcpt_d = NO_XCPT;
    if (!legal) begin
      res_d  = '0;
      xcpt_d = ILLEGAL_MUL;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pipeline
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= mul_valid;
      for (int i = 1; i < DEPTH; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    res_q[0]  <= res_d;
    rd_q[0]   <= rd;
    xcpt_q[0] <= xcpt_d;
    for (int i = 1; i < DEPTH; i++) begin
      res_q[i]  <= res_q[i-1];
      rd_q[i]   <= rd_q[i-1];
      xcpt_q[i] <= xcpt_q[i-1];
    end
  end

  assign out.valid = valid_q[DEPTH-1];
  assign out.res   = res_q[DEPTH-1];
  assign out.rd    = rd_q[DEPTH-1];
  assign out.xcpt  = xcpt_q[DEPTH-1];

  // ALU issue now would land in WB with this multiply.
  assign alu_stall = valid_q[MUL_STAGES-2];

endmodule

/* hw/wb/wb_stage.sv */
`timescale 1ns/1ps

module wb_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush,
  alu_wb_if.wb_dst             alu_in,
  mul_wb_if.wb_dst             mul_in,
  input  brisc_pkg::xlen_t     read_data,
  output logic                 rf_we,
  output brisc_pkg::reg_addr_t rf_waddr,
  output brisc_pkg::xlen_t     rf_wdata,
  output logic                 wb_valid,
  output brisc_pkg::reg_addr_t wb_rd,
  output brisc_pkg::xlen_t     wb_result,
  output brisc_ctrl_pkg::xcpt_e wb_xcpt
);
  import brisc_pkg::*;
  import brisc_ctrl_pkg::*;

  logic        alu_valid_q;
  xlen_t       alu_res_q;
  reg_addr_t   alu_rd_q;
  logic        alu_reg_write_q;
  result_src_e alu_src_q;
  xlen_t       alu_pc4_q;
  xcpt_e       alu_xcpt_q;
  xlen_t       read_data_q;

  logic        mul_valid_q;
  xlen_t       mul_res_q;
  reg_addr_t   mul_rd_q;
  xcpt_e       mul_xcpt_q;

  logic        writes;

  //////////////////////////////////////////////////////////////////////
  // C to WB registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      alu_valid_q <= 1'b0;
      mul_valid_q <= 1'b0;
    end else begin
      alu_valid_q <= alu_in.valid;
      mul_valid_q <= mul_in.valid;
    end
  end

  always_ff @(posedge clk) begin
    alu_res_q       <= alu_in.res;
    alu_rd_q        <= alu_in.rd;
    alu_reg_write_q <= alu_in.reg_write;
    alu_src_q       <= alu_in.result_src;
    alu_pc4_q       <= alu_in.pc_plus4;
    alu_xcpt_q      <= alu_in.xcpt;
    // Cache data belongs to the load now in C.
    read_data_q     <= read_data;
    mul_res_q       <= mul_in.res;
    mul_rd_q        <= mul_in.rd;
    mul_xcpt_q      <= mul_in.xcpt;
  end

  //////////////////////////////////////////////////////////////////////
  // Result select and arbitration
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    wb_rd     = '0;
    wb_result = '0;
    wb_xcpt   = NO_XCPT;
    writes    = 1'b0;
    if (alu_valid_q) begin
      case (alu_src_q)
        FROM_ALU:     wb_result = alu_res_q;
        FROM_CACHE:   wb_result = read_data_q;
        FROM_PC_NEXT: wb_result = alu_pc4_q;
        default:      wb_result = '0;
      endcase
      wb_rd   = alu_rd_q;
      wb_xcpt = alu_xcpt_q;
      writes  = alu_reg_write_q;
    end else if (mul_valid_q) begin
      wb_result = mul_res_q;
      wb_rd     = mul_rd_q;
      wb_xcpt   = mul_xcpt_q;
      writes    = 1'b1;
    end
  end

  assign wb_valid = alu_valid_q | mul_valid_q;

  // Excepting instructions never reach the register file.
  assign rf_we    = writes && (wb_xcpt == NO_XCPT);
  assign rf_waddr = wb_rd;
  assign rf_wdata = wb_result;

endmodule

/* hw/regfile.sv */
`timescale 1ns/1ps

module regfile (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 we,
  input  brisc_pkg::reg_addr_t waddr,
  input  brisc_pkg::xlen_t     wdata,
  input  brisc_pkg::reg_addr_t dbg_addr,
  output brisc_pkg::xlen_t     dbg_data
);
  import brisc_pkg::*;

  localparam int unsigned NUM_REGS = 1 << REG_ADDR_W;

  xlen_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      // x0 stays zero.
      regs[waddr] <= wdata;
    end
  end

  assign dbg_data = regs[dbg_addr];

endmodule

/* hw/brisc_backend.sv */
`timescale 1ns/1ps

module brisc_backend #(
  parameter int unsigned MUL_STAGES = 3
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       flush,
  input  logic                       alu_valid,
  input  brisc_ctrl_pkg::alu_op_e     alu_op,
  input  brisc_pkg::xlen_t           alu_a,
  input  brisc_pkg::xlen_t           alu_b,
  input  brisc_pkg::xlen_t           alu_pc_plus4,
  input  brisc_pkg::reg_addr_t       alu_rd,
  input  logic                       alu_reg_write,
  input  brisc_ctrl_pkg::result_src_e alu_result_src,
  input  logic                       mul_valid,
  input  brisc_ctrl_pkg::mul_op_e     mul_op,
  input  brisc_pkg::xlen_t           mul_a,
  input  brisc_pkg::xlen_t           mul_b,
  input  brisc_pkg::reg_addr_t       mul_rd,
  input  brisc_pkg::xlen_t           read_data,
  input  brisc_pkg::reg_addr_t       dbg_addr,
  output logic                       alu_stall,
  output logic                       wb_valid,
  output brisc_pkg::reg_addr_t       wb_rd,
  output brisc_pkg::xlen_t           wb_result,
  output brisc_ctrl_pkg::xcpt_e       wb_xcpt,
  output brisc_pkg::xlen_t           dbg_data
);
  import brisc_pkg::*;

  logic      rf_we;
  reg_addr_t rf_waddr;
  xlen_t     rf_wdata;

  alu_wb_if alu_wb ();
  mul_wb_if mul_wb ();

  alu_unit u_alu (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .alu_valid  (alu_valid),
    .alu_op     (alu_op),
    .op_a       (alu_a),
    .op_b       (alu_b),
    .pc_plus4   (alu_pc_plus4),
    .rd         (alu_rd),
    .reg_write  (alu_reg_write),
    .result_src (alu_result_src),
    .alu_stall  (alu_stall),
    .out        (alu_wb)
  );

  mul_unit #(
    .MUL_STAGES (MUL_STAGES)
  ) u_mul (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .mul_valid (mul_valid),
    .mul_op    (mul_op),
    .op_a      (mul_a),
    .op_b      (mul_b),
    .rd        (mul_rd),
    .out       (mul_wb),
    .alu_stall (alu_stall)
  );

  wb_stage u_wb (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .alu_in    (alu_wb),
    .mul_in    (mul_wb),
    .read_data (read_data),
    .rf_we     (rf_we),
    .rf_waddr  (rf_waddr),
    .rf_wdata  (rf_wdata),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_result (wb_result),
    .wb_xcpt   (wb_xcpt)
  );

  regfile u_rf (
    .clk      (clk),
    .rst_n    (rst_n),
    .we       (rf_we),
    .waddr    (rf_waddr),
    .wdata    (rf_wdata),
    .dbg_addr (dbg_addr),
    .dbg_data (dbg_data)
  );

endmodule

/* verif/tb_backend.sv */
`timescale 1ns/1ps

module tb_backend;
  import brisc_pkg::*;
  import brisc_ctrl_pkg::*;

  // Matches the DUT default.
  localparam int MUL_STAGES = 3;
  // Edges from issue to the edge after which wb_valid shows the result.
  localparam int ALU_LAT = 1;
  localparam int MUL_LAT = MUL_STAGES;

  localparam int N_ALU = 40;
  localparam int N_SRC = 24;
  localparam int N_MUL = 26;
  localparam int N_MIX = 120;
  localparam int N_ISSUED = N_ALU + N_SRC + N_MUL + 2 * N_MIX + 34 + 14;
  localparam int WATCHDOG_CYCLES = N_ISSUED * (MUL_STAGES + 4) + 7 * 32 + 100;

  typedef struct packed {
    int        arrive;
    reg_addr_t rd;
    xlen_t     result;
    xcpt_e     xcpt;
    logic      writes;
  } exp_t;

  logic        clk;
  logic        rst_n;
  logic        flush;
  logic        alu_valid;
  alu_op_e     alu_op;
  xlen_t       alu_a;
  xlen_t       alu_b;
  xlen_t       alu_pc_plus4;
  reg_addr_t   alu_rd;
  logic        alu_reg_write;
  result_src_e alu_result_src;
  logic        mul_valid;
  mul_op_e     mul_op;
  xlen_t       mul_a;
  xlen_t       mul_b;
  reg_addr_t   mul_rd;
  xlen_t       read_data;
  reg_addr_t   dbg_addr;
  logic        alu_stall;
  logic        wb_valid;
  reg_addr_t   wb_rd;
  xlen_t       wb_result;
  xcpt_e       wb_xcpt;
  xlen_t       dbg_data;

  exp_t        exp_q[$];
  exp_t        cur;
  xlen_t       shadow [32];
  int          edge_cnt;
  int          stall_cnt;
  int          purged_cnt;
  xlen_t       rdata_next;

  // Instruction waiting for issue.
  bit          alu_pend;
  alu_op_e     pa_op;
  xlen_t       pa_a;
  xlen_t       pa_b;
  xlen_t       pa_pc4;
  reg_addr_t   pa_rd;
  logic        pa_wr;
  result_src_e pa_src;
  bit          mul_pend;
  logic [2:0]  pm_op;
  xlen_t       pm_a;
  xlen_t       pm_b;
  reg_addr_t   pm_rd;

  brisc_backend dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    edge_cnt++;
  end

  //////////////////////////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////////////////////////

  task automatic end_with_failure();
    $display("Test failed");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic report_error(input string why);
    $display("ERROR: %s", why);
    end_with_failure();
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED: %s got 0x%08h expected 0x%08h", name, got, exp);
      end_with_failure();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic exp_t predict_wb(input bit is_mul, input logic [2:0] op,
                                      input xlen_t a, input xlen_t b, input xlen_t pc4,
                                      input reg_addr_t rd, input logic wr,
                                      input result_src_e src, input xlen_t rdata);
    exp_t        e;
    xlen_t       val;
    logic [63:0] a64;
    logic [63:0] b64;
    logic [63:0] prod;
    e.arrive = 0;
    e.rd     = rd;
    e.result = '0;
    e.xcpt   = NO_XCPT;
    e.writes = wr;
    if (is_mul) begin
      // Sign or zero extend to 64 bits so the product is exact mod 2^64.
      a64 = {{32{(op == MULH || op == MULHSU) & a[31]}}, a};
      b64 = {{32{(op == MULH) & b[31]}}, b};
      prod = a64 * b64;
      e.writes = 1'b1;
      case (op)
        MUL:                 e.result = prod[31:0];
        MULH, MULHSU, MULHU: e.result = prod[63:32];
        default:             e.xcpt = ILLEGAL_MUL;
      endcase
    end else begin
      case (op)
        ADD:     val = a + b;
        SUB:     val = a - b;
        AND:     val = a & b;
        OR:      val = a | b;
        XOR:     val = a ^ b;
        SLT:     val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        SLL:     val = a << b[4:0];
        default: val = a >> b[4:0];
      endcase
      case (src)
        FROM_CACHE: begin
          e.result = rdata;
          if (val[1:0] != 2'b00) begin
            e.xcpt = LOAD_MISALIGNED;
          end
        end
        FROM_PC_NEXT: e.result = pc4;
        default:      e.result = val;
      endcase
    end
    return e;
  endfunction

  // An ALU issue now would meet a multiply already in flight at WB.
  function automatic logic stall_expected(input int issue_edge);
    logic hit;
    hit = 1'b0;
    foreach (exp_q[i]) begin
      if (exp_q[i].arrive == issue_edge + ALU_LAT) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // Keeps the queue sorted by arrival edge.
  task automatic push_expected(input exp_t e);
    int i;
    i = exp_q.size();
    while (i > 0 && exp_q[i-1].arrive > e.arrive) begin
      i--;
    end
    if (i > 0 && exp_q[i-1].arrive == e.arrive) begin
      report_error($sformatf("two writebacks predicted for edge %0d", e.arrive));
    end
    exp_q.insert(i, e);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  function automatic xlen_t rand_operand();
    case ($urandom % 4)
      0:       return xlen_t'($urandom % 16);
      1:       return xlen_t'(0 - ($urandom % 16));
      2:       return 32'h8000_0000 | $urandom;
      default: return $urandom;
    endcase
  endfunction

  task automatic set_alu(input alu_op_e op, input xlen_t a, input xlen_t b,
                         input reg_addr_t rd, input logic wr, input result_src_e src);
    pa_op    = op;
    pa_a     = a;
    pa_b     = b;
    pa_pc4   = $urandom & 32'hffff_fffc;
    pa_rd    = rd;
    pa_wr    = wr;
    pa_src   = src;
    alu_pend = 1'b1;
  endtask

  task automatic set_mul(input logic [2:0] op, input xlen_t a, input xlen_t b,
                         input reg_addr_t rd);
    pm_op    = op;
    pm_a     = a;
    pm_b     = b;
    pm_rd    = rd;
    mul_pend = 1'b1;
  endtask

  task automatic rand_alu(input result_src_e src, input bit misalign);
    xlen_t     base;
    reg_addr_t rd;
    base = $urandom & 32'hffff_fffc;
    rd   = reg_addr_t'($urandom);
    if (src != FROM_CACHE) begin
      set_alu(alu_op_e'(3'($urandom)), rand_operand(), rand_operand(), rd,
              ($urandom % 8) != 0, src);
    end else if (misalign) begin
      set_alu(ADD, base, xlen_t'(1 + $urandom % 3), rd, 1'b1, src);
    end else begin
      set_alu(ADD, base, xlen_t'(($urandom % 64) << 2), rd, 1'b1, src);
    end
  endtask

  task automatic rand_mul(input bit legal);
    logic [2:0] op;
    op = legal ? 3'($urandom % 4) : 3'(4 + $urandom % 4);
    set_mul(op, rand_operand(), rand_operand(), reg_addr_t'($urandom));
  endtask

  // One clock of issue. An ALU op refused by alu_stall stays pending.
  task automatic drive_cycle();
    exp_t e;
    int   issue_edge;
    @(negedge clk);
    flush          = 1'b0;
    read_data      = rdata_next;
    rdata_next     = $urandom;
    alu_valid      = alu_pend;
    alu_op         = pa_op;
    alu_a          = pa_a;
    alu_b          = pa_b;
    alu_pc_plus4   = pa_pc4;
    alu_rd         = pa_rd;
    alu_reg_write  = pa_wr;
    alu_result_src = pa_src;
    mul_valid      = mul_pend;
    mul_op         = mul_op_e'(pm_op);
    mul_a          = pm_a;
    mul_b          = pm_b;
    mul_rd         = pm_rd;
    #1;
    issue_edge = edge_cnt + 1;
    check_value("alu_stall", alu_stall, stall_expected(issue_edge));
    if (mul_pend) begin
      e = predict_wb(1'b1, pm_op, pm_a, pm_b, '0, pm_rd, 1'b1, FROM_ALU, '0);
      e.arrive = issue_edge + MUL_LAT;
      push_expected(e);
      mul_pend = 1'b0;
    end
    if (alu_pend && !alu_stall) begin
      // Cache data for this load is driven in its C cycle at the next falling edge.
      e = predict_wb(1'b0, pa_op, pa_a, pa_b, pa_pc4, pa_rd, pa_wr, pa_src, rdata_next);
      e.arrive = issue_edge + ALU_LAT;
      push_expected(e);
      alu_pend = 1'b0;
    end else if (alu_pend) begin
      stall_cnt++;
    end
  endtask

  task automatic flush_cycle();
    int flush_edge;
    @(negedge clk);
    flush      = 1'b1;
    alu_valid  = 1'b0;
    mul_valid  = 1'b0;
    flush_edge = edge_cnt + 1;
    // Anything not yet shown at WB by the flush edge is gone.
    for (int i = exp_q.size() - 1; i >= 0; i--) begin
      if (exp_q[i].arrive >= flush_edge) begin
        exp_q.delete(i);
        purged_cnt++;
      end
    end
  endtask

  task automatic drain();
    while (alu_pend || exp_q.size() != 0) begin
      drive_cycle();
    end
    repeat (2) drive_cycle();
  endtask

  task automatic sweep_regs();
    for (int i = 0; i < 32; i++) begin
      @(negedge clk);
      dbg_addr = reg_addr_t'(i);
      #1;
      check_value($sformatf("dbg_data[x%0d]", i), dbg_data, shadow[i]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Writeback compare
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      if (wb_valid) begin
        if (exp_q.size() == 0) begin
          report_error("wb_valid went high with no instruction in flight");
        end else begin
          cur = exp_q.pop_front();
          check_value("wb arrival edge", edge_cnt, cur.arrive);
          check_value("wb_rd", wb_rd, cur.rd);
          check_value("wb_result", wb_result, cur.result);
          check_value("wb_xcpt", wb_xcpt, cur.xcpt);
          if (cur.writes && cur.xcpt == NO_XCPT && cur.rd != '0) begin
            shadow[cur.rd] = cur.result;
          end
        end
      end else if (exp_q.size() != 0 && exp_q[0].arrive <= edge_cnt) begin
        report_error($sformatf("no writeback seen for rd x%0d due at edge %0d",
                               exp_q[0].rd, exp_q[0].arrive));
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("ERROR: timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    end_with_failure();
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'heaaa_12d1));
    rst_n = 1'b0;
    flush = 1'b0;
    alu_valid = 1'b0;
    alu_op = ADD;
    alu_a = '0;
    alu_b = '0;
    alu_pc_plus4 = '0;
    alu_rd = '0;
    alu_reg_write = 1'b0;
    alu_result_src = FROM_ALU;
    mul_valid = 1'b0;
    mul_op = MUL;
    mul_a = '0;
    mul_b = '0;
    mul_rd = '0;
    read_data = '0;
    dbg_addr = '0;
    edge_cnt = 0;
    stall_cnt = 0;
    purged_cnt = 0;
    alu_pend = 1'b0;
    mul_pend = 1'b0;
    pa_op = ADD;
    pa_a = '0;
    pa_b = '0;
    pa_pc4 = '0;
    pa_rd = '0;
    pa_wr = 1'b0;
    pa_src = FROM_ALU;
    pm_op = '0;
    pm_a = '0;
    pm_b = '0;
    pm_rd = '0;
    rdata_next = $urandom;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end

    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_value("wb_valid", wb_valid, 1'b0);
    check_value("alu_stall", alu_stall, 1'b0);
    check_value("wb_xcpt", wb_xcpt, NO_XCPT);
    sweep_regs();

    // Plain ALU results.
    for (int i = 0; i < N_ALU; i++) begin
      rand_alu(FROM_ALU, 1'b0);
      drive_cycle();
    end
    drain();

    // Loads, PC+4 and misaligned loads.
    for (int i = 0; i < N_SRC; i++) begin
      case (i % 3)
        0:       rand_alu(FROM_CACHE, 1'b0);
        1:       rand_alu(FROM_PC_NEXT, 1'b0);
        default: rand_alu(FROM_CACHE, 1'b1);
      endcase
      drive_cycle();
    end
    drain();
    sweep_regs();

    // Multiplies back to back, a few illegal codes.
    for (int i = 0; i < N_MUL; i++) begin
      rand_mul((i % 12) != 11);
      drive_cycle();
    end
    drain();
    sweep_regs();

    // Mixed issue with stalls.
    stall_cnt = 0;
    for (int i = 0; i < N_MIX; i++) begin
      if (!alu_pend && ($urandom % 2) == 0) begin
        rand_alu(result_src_e'(2'($urandom % 3)), ($urandom % 8) == 0);
      end
      if (($urandom % 3) == 0) begin
        rand_mul(($urandom % 10) != 0);
      end
      drive_cycle();
    end
    drain();
    if (stall_cnt == 0) begin
      report_error("mixed issue never stalled the ALU");
    end

    // Write every register, x0 included.
    for (int i = 0; i < 32; i++) begin
      set_alu(ADD, rand_operand(), rand_operand(), reg_addr_t'(i), 1'b1, FROM_ALU);
      drive_cycle();
    end
    set_mul(3'(MUL), rand_operand(), 32'd7, '0);
    drive_cycle();
    set_alu(OR, 32'hdead_beef, 32'h1, '0, 1'b1, FROM_ALU);
    drive_cycle();
    drain();
    sweep_regs();

    // Flush with an ALU op in C and a multiply in flight.
    purged_cnt = 0;
    rand_alu(FROM_ALU, 1'b0);
    rand_mul(1'b1);
    drive_cycle();
    flush_cycle();
    if (purged_cnt != 2) begin
      report_error($sformatf("flush removed %0d entries instead of 2", purged_cnt));
    end
    for (int i = 0; i < 6; i++) begin
      rand_alu(FROM_ALU, 1'b0);
      if (i % 2 == 0) begin
        rand_mul(1'b1);
      end
      drive_cycle();
    end
    drain();
    sweep_regs();

    if (exp_q.size() != 0) begin
      $display("ERROR: %0d expected writebacks never appeared", exp_q.size());
      end_with_failure();
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

/* build.f */
common/brisc_pkg.sv
common/brisc_ctrl_pkg.sv
common/exec_wb_if.sv
hw/alu/alu_unit.sv
hw/mul/mul_unit.sv
hw/wb/wb_stage.sv
hw/regfile.sv
hw/brisc_backend.sv
verif/tb_backend.sv

/* Bender.yml */
package:
  name: brisc_backend

sources:
  - common/brisc_pkg.sv
  - common/brisc_ctrl_pkg.sv
  - common/exec_wb_if.sv
  - hw/alu/alu_unit.sv
  - hw/mul/mul_unit.sv
  - hw/wb/wb_stage.sv
  - hw/regfile.sv
  - hw/brisc_backend.sv
  - target: test
    files:
      - verif/tb_backend.sv
